// File: mover_consts.svh
// Sizing constants for the data mover; BANK_DEPTH must equal 2**ADDR_WIDTH and FIFO_DEPTH must be at least 2

`ifndef MOVER_CONSTS_SVH
`define MOVER_CONSTS_SVH

// Width of one data word in both banks and in the FIFO
`define DATA_WIDTH 32

// Register address width, shared by the source and target banks
`define ADDR_WIDTH 4

// Number of registers in each bank
`define BANK_DEPTH 16

// Number of channels the mover steps through on every pass
`define CHANNEL_COUNT 4

// Number of tagged transfers the FIFO can hold
`define FIFO_DEPTH 4

`endif

// File: mover_pkg.sv
// Shared types for the data mover; widths follow mover_consts.svh and channel_t assumes CHANNEL_COUNT > 1

`include "mover_consts.svh"

package mover_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;
    typedef logic [$clog2(`CHANNEL_COUNT)-1:0] channel_t;

    // Read request from the mover to the source bank
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } read_request_t;

    // Read response, one cycle after the request
    typedef struct packed {
        logic  strobe;
        word_t data;
    } read_response_t;

    // A data word tagged with the register it is bound for
    typedef struct packed {
        addr_t target;
        word_t data;
    } transfer_t;

    // One write into the channel table
    typedef struct packed {
        logic     write;
        channel_t channel;
        addr_t    source;
        addr_t    target;
    } channel_cfg_t;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        issue = 2'd1,
        await = 2'd2
    } mover_state_t;

endpackage

// File: source_bank.sv
// Source register file; a read and an external write of the same register in one cycle return the old value

`timescale 1ns/1ps
`include "mover_consts.svh"

module source_bank (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       src_write,
    input  mover_pkg::addr_t           src_addr,
    input  mover_pkg::word_t           src_data,
    input  mover_pkg::read_request_t   request,
    output mover_pkg::read_response_t  response
);

    mover_pkg::word_t regs [`BANK_DEPTH];

    // External write port
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (src_write) begin
                regs[src_addr] <= src_data;
            end
        end
    end

    // The response is registered, so it lands exactly one cycle after the request
    // and samples the register before any write of the same edge takes effect
    always_ff @(posedge clock) begin
        if (!reset) begin
            response <= '0;
        end else begin
            response.strobe <= request.strobe;
            if (request.strobe) begin
                response.data <= regs[request.addr];
            end
        end
    end

endmodule

// File: channel_mover.sv
// Channel sequencer; a table write during a pass only reaches channels that have not been issued yet

`timescale 1ns/1ps
`include "mover_consts.svh"

module channel_mover (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  mover_pkg::channel_cfg_t    cfg,
    input  logic                       full,
    output mover_pkg::read_request_t   request,
    input  mover_pkg::read_response_t  response,
    output logic                       push,
    output mover_pkg::transfer_t       transfer,
    output logic                       busy
);

    localparam mover_pkg::channel_t LAST_CHANNEL = mover_pkg::channel_t'(`CHANNEL_COUNT - 1);

    mover_pkg::addr_t src_table [`CHANNEL_COUNT];
    mover_pkg::addr_t tgt_table [`CHANNEL_COUNT];

    mover_pkg::mover_state_t state;
    mover_pkg::channel_t     channel;
    logic                    word_held;

    assign busy = (state != mover_pkg::idle);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= mover_pkg::idle;
            channel   <= '0;
            word_held <= 1'b0;
            request   <= '0;
            push      <= 1'b0;
            transfer  <= '0;
            // Identity mapping until the table is programmed
            for (int i = 0; i < `CHANNEL_COUNT; i++) begin
                src_table[i] <= mover_pkg::addr_t'(i);
                tgt_table[i] <= mover_pkg::addr_t'(i);
            end
        end else begin
            request.strobe <= 1'b0;
            push           <= 1'b0;

            if (cfg.write) begin
                src_table[cfg.channel] <= cfg.source;
                tgt_table[cfg.channel] <= cfg.target;
            end

            case (state)
                mover_pkg::idle: begin
                    if (start) begin
                        state <= mover_pkg::issue;
                    end
                end
                mover_pkg::issue: begin
                    // The target is latched with the request so a later table
                    // write cannot retag a channel already in flight
                    if (!full) begin
                        request.strobe  <= 1'b1;
                        request.addr    <= src_table[channel];
                        transfer.target <= tgt_table[channel];
                        state           <= mover_pkg::await;
                    end
                end
                mover_pkg::await: begin
                    if (response.strobe) begin
                        transfer.data <= response.data;
                    end
                    // A word can be kept back when the previous push filled the FIFO
                    // after this channel was already issued
                    if ((response.strobe || word_held) && !full) begin
                        push      <= 1'b1;
                        word_held <= 1'b0;
                        if (channel == LAST_CHANNEL) begin
                            channel <= '0;
                            state   <= mover_pkg::idle;
                        end else begin
                            channel <= channel + mover_pkg::channel_t'(1);
                            state   <= mover_pkg::issue;
                        end
                    end else if (response.strobe) begin
                        word_held <= 1'b1;
                    end
                end
                default: begin
                    state <= mover_pkg::idle;
                end
            endcase
        end
    end

endmodule

// File: dest_fifo.sv
// Transfer FIFO; the producer must not push while full and the consumer must not pop while empty

`timescale 1ns/1ps
`include "mover_consts.svh"

module dest_fifo (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push,
    input  mover_pkg::transfer_t  push_data,
    input  logic                  pop,
    output mover_pkg::transfer_t  head,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_WIDTH   = $clog2(`FIFO_DEPTH);
    localparam int COUNT_WIDTH = $clog2(`FIFO_DEPTH + 1);

    localparam logic [PTR_WIDTH-1:0]   LAST_SLOT = PTR_WIDTH'(`FIFO_DEPTH - 1);
    localparam logic [COUNT_WIDTH-1:0] MAX_COUNT = COUNT_WIDTH'(`FIFO_DEPTH);

    mover_pkg::transfer_t mem [`FIFO_DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;

    // Entry storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is read straight from storage, so a push shows up on the next cycle
    assign head  = mem[rd_ptr];
    assign full  = (count == MAX_COUNT);
    assign empty = (count == '0);

endmodule

// File: target_bank.sv
// Target register file; hold is the only back-pressure and readback is combinational from the registers

`timescale 1ns/1ps
`include "mover_consts.svh"

module target_bank (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  hold,
    input  mover_pkg::transfer_t  head,
    input  logic                  empty,
    output logic                  pop,
    input  mover_pkg::addr_t      tgt_addr,
    output mover_pkg::word_t      tgt_data
);

    mover_pkg::word_t regs [`BANK_DEPTH];

    // Take the head whenever one waits and the consumer is not held
    assign pop = !empty && !hold;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `BANK_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (pop) begin
                regs[head.target] <= head.data;
            end
        end
    end

    // A popped word is visible here on the cycle after the pop
    assign tgt_data = regs[tgt_addr];

endmodule

// File: mover_top.sv
// Top level of the data mover; start is a one-cycle pulse and is ignored while busy is high

`timescale 1ns/1ps
`include "mover_consts.svh"

module mover_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     src_write,
    input  mover_pkg::addr_t         src_addr,
    input  mover_pkg::word_t         src_data,
    input  mover_pkg::channel_cfg_t  cfg,
    input  logic                     start,
    input  logic                     hold,
    input  mover_pkg::addr_t         tgt_addr,
    output mover_pkg::word_t         tgt_data,
    output logic                     busy
);

    mover_pkg::read_request_t  request;
    mover_pkg::read_response_t response;
    mover_pkg::transfer_t      transfer;
    mover_pkg::transfer_t      head;

    logic push;
    logic pop;
    logic full;
    logic empty;

    source_bank i_source_bank (
        .clock     (clock),
        .reset     (reset),
        .src_write (src_write),
        .src_addr  (src_addr),
        .src_data  (src_data),
        .request   (request),
        .response  (response)
    );

    channel_mover i_channel_mover (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .cfg      (cfg),
        .full     (full),
        .request  (request),
        .response (response),
        .push     (push),
        .transfer (transfer),
        .busy     (busy)
    );

    dest_fifo i_dest_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .push_data (transfer),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    target_bank i_target_bank (
        .clock    (clock),
        .reset    (reset),
        .hold     (hold),
        .head     (head),
        .empty    (empty),
        .pop      (pop),
        .tgt_addr (tgt_addr),
        .tgt_data (tgt_data)
    );

endmodule

// File: mover_props.sv
// Concurrent checks bound to mover_top; they assume start is a one-cycle pulse and hold stays put during a pass

`timescale 1ns/1ps

module mover_props (
    input logic                       clock,
    input logic                       reset,
    input logic                       start,
    input logic                       hold,
    input logic                       busy,
    input logic                       push,
    input logic                       full,
    input mover_pkg::read_request_t   request,
    input mover_pkg::read_response_t  response
);

    // Busy is clear on the cycle after reset is seen
    busy_after_reset: assert property (
        @(posedge clock) !reset |=> !busy
    ) else $error("busy is high after reset");

    // The FIFO is never pushed while it is full
    push_not_full: assert property (
        @(posedge clock) disable iff (!reset)
        push |-> !full
    ) else $error("push strobe high while the FIFO is full");

    // Every read request is answered on the very next cycle
    response_follows_request: assert property (
        @(posedge clock) disable iff (!reset)
        request.strobe |=> response.strobe
    ) else $error("no read response one cycle after a read request");

    // With no back-pressure a full pass is twelve cycles, so busy falls
    // on the twelfth edge after the start is taken
    pass_length: assert property (
        @(posedge clock) disable iff (!reset)
        (start && !busy && !hold) |-> ##13 $fell(busy)
    ) else $error("busy did not fall twelve cycles after a start with hold low");

endmodule

// File: mover_tb.sv
// Testbench for mover_top; inputs change on the falling edge and the run stops at a fixed cycle limit

`timescale 1ns/1ps
`include "mover_consts.svh"

module mover_tb;

    localparam int EXPECTED_CYCLES = 1000;
    localparam int TIMEOUT_CYCLES  = 3 * EXPECTED_CYCLES;
    localparam int IDLE_LIMIT      = 200;
    localparam int DRAIN_CYCLES    = 8;

    logic                    clock;
    logic                    reset;
    logic                    src_write;
    mover_pkg::addr_t        src_addr;
    mover_pkg::word_t        src_data;
    mover_pkg::channel_cfg_t cfg;
    logic                    start;
    logic                    hold;
    mover_pkg::addr_t        tgt_addr;
    mover_pkg::word_t        tgt_data;
    logic                    busy;

    // Reference model of both banks and the channel table
    mover_pkg::word_t src_model [`BANK_DEPTH];
    mover_pkg::word_t tgt_model [`BANK_DEPTH];
    mover_pkg::addr_t tab_src [`CHANNEL_COUNT];
    mover_pkg::addr_t tab_tgt [`CHANNEL_COUNT];

    logic [31:0] lcg_state;
    int          errors;
    int          cycle_count;

    mover_top i_dut (
        .clock     (clock),
        .reset     (reset),
        .src_write (src_write),
        .src_addr  (src_addr),
        .src_data  (src_data),
        .cfg       (cfg),
        .start     (start),
        .hold      (hold),
        .tgt_addr  (tgt_addr),
        .tgt_data  (tgt_data),
        .busy      (busy)
    );

    bind mover_top mover_props i_props (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .hold     (hold),
        .busy     (busy),
        .push     (push),
        .full     (full),
        .request  (request),
        .response (response)
    );

    always #10 clock = ~clock;

    // Watchdog so a stuck mover cannot hang the run
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles with tests still running", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fill_sources_random();
        for (int i = 0; i < `BANK_DEPTH; i++) begin
            @(negedge clock);
            src_write = 1'b1;
            src_addr  = mover_pkg::addr_t'(i);
            src_data  = next_random();
            src_model[i] = src_data;
        end
        @(negedge clock);
        src_write = 1'b0;
    endtask

    task automatic program_channel(input mover_pkg::channel_t ch, input mover_pkg::addr_t source,
                                   input mover_pkg::addr_t target);
        @(negedge clock);
        cfg.write   = 1'b1;
        cfg.channel = ch;
        cfg.source  = source;
        cfg.target  = target;
        tab_src[ch] = source;
        tab_tgt[ch] = target;
        @(negedge clock);
        cfg = '0;
    endtask

    task automatic pulse_start();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < IDLE_LIMIT) begin
            @(negedge clock);
            n++;
        end
        assert (!busy) else begin
            errors++;
            $display("Mover still busy %0d cycles after the wait began", IDLE_LIMIT);
        end
    endtask

    // Channels are copied in ascending order, so the highest channel wins a shared target
    task automatic apply_model_pass();
        for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
            tgt_model[tab_tgt[ch]] = src_model[tab_src[ch]];
        end
    endtask

    task automatic check_busy(input logic expected);
        assert (busy === expected) else begin
            errors++;
            $display("ERR busy: expected %h, got %h", expected, busy);
        end
    endtask

    task automatic check_targets();
        for (int a = 0; a < `BANK_DEPTH; a++) begin
            @(negedge clock);
            tgt_addr = mover_pkg::addr_t'(a);
            #5;
            assert (tgt_data === tgt_model[a]) else begin
                errors++;
                $display("ERR tgt_data at address %h: expected %h, got %h",
                         a[3:0], tgt_model[a], tgt_data);
            end
        end
    endtask

    task automatic run_pass();
        pulse_start();
        wait_idle();
        repeat (DRAIN_CYCLES) @(negedge clock);
        apply_model_pass();
        check_targets();
    endtask

    initial begin
        logic [31:0] rnd;
        clock       = 1'b0;
        reset       = 1'b0;
        src_write   = 1'b0;
        src_addr    = '0;
        src_data    = '0;
        cfg         = '0;
        start       = 1'b0;
        hold        = 1'b0;
        tgt_addr    = '0;
        errors      = 0;
        cycle_count = 0;
        lcg_state   = 32'hc0c;
        for (int i = 0; i < `BANK_DEPTH; i++) begin
            src_model[i] = '0;
            tgt_model[i] = '0;
        end
        for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
            tab_src[ch] = mover_pkg::addr_t'(ch);
            tab_tgt[ch] = mover_pkg::addr_t'(ch);
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        // Reset state
        check_busy(1'b0);
        check_targets();

        // Identity table from reset
        fill_sources_random();
        run_pass();

        // Permuted sources, with channels 0 and 2 sharing target 5
        program_channel(2'd0, 4'd9, 4'd5);
        program_channel(2'd1, 4'd3, 4'd12);
        program_channel(2'd2, 4'd14, 4'd5);
        program_channel(2'd3, 4'd0, 4'd7);
        run_pass();

        // Back-pressure: the first pass fills the FIFO and the second one stalls
        fill_sources_random();
        @(negedge clock);
        hold = 1'b1;
        pulse_start();
        wait_idle();
        pulse_start();
        repeat (20) @(negedge clock);
        check_busy(1'b1);
        check_targets();
        check_busy(1'b1);
        @(negedge clock);
        hold = 1'b0;
        wait_idle();
        repeat (DRAIN_CYCLES) @(negedge clock);
        apply_model_pass();
        apply_model_pass();
        check_targets();

        // Starts during a pass are dropped and new sources are not picked up
        fill_sources_random();
        pulse_start();
        repeat (2) @(negedge clock);
        pulse_start();
        @(negedge clock);
        pulse_start();
        wait_idle();
        apply_model_pass();
        fill_sources_random();
        repeat (DRAIN_CYCLES) @(negedge clock);
        check_busy(1'b0);
        check_targets();

        // Random sources and tables
        for (int pass = 0; pass < 8; pass++) begin
            fill_sources_random();
            for (int ch = 0; ch < `CHANNEL_COUNT; ch++) begin
                rnd = next_random();
                program_channel(mover_pkg::channel_t'(ch), mover_pkg::addr_t'(rnd[7:0]),
                                mover_pkg::addr_t'(rnd[15:8]));
            end
            run_pass();
        end

        $display("Checks finished with %0d errors after %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
mover_pkg.sv
source_bank.sv
channel_mover.sv
dest_fifo.sv
target_bank.sv
mover_top.sv
mover_props.sv
mover_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the data mover testbench with Verilator, runs it and checks the log for the pass line

rm -f build.log sim.log

verilator --binary --timing --assert --top-module mover_tb -f flist.f -o mover_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/mover_sim > sim.log 2>&1

grep -qx "Testbench passed" sim.log && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors, see sim.log"; exit 1; }
